/* bench/clockGen.sv */
`timescale 1ns/1ns

module clockGen #(
    parameter int halfPeriod  = 2,    // 4 ns clock
    parameter int resetCycles = 10
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #halfPeriod clk = ~clk;
    end

    // Synchronous reset released on a rising edge
    initial begin
        rst = 1'b1;
        repeat (resetCycles) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

/* bench/stcDacBench.sv */
`timescale 1ns/1ns

module stcDacBench;

    import stcPkg::*;

    localparam int          numDacs      = 3;
    localparam logic [15:0] verNumber    = 16'd646;
    localparam int          streamLen    = 24;    // Cycles per stream row
    localparam int          resetTimeout = 40;

    localparam logic [1:0] opWrite  = 2'd0;
    localparam logic [1:0] opRead   = 2'd1;
    localparam logic [1:0] opStream = 2'd2;

    // Read rows hold the read data in expected
    // Stream rows hold the route code in expected and the test value in data
    typedef struct packed {
        logic [1:0]           op;
        logic [addrWidth-1:0] addr;
        logic [31:0]          data;
        logic [3:0]           strobes;
        logic [1:0]           chan;
        logic [17:0]          expected;
    } stimRowT;

    localparam int numRows = 37;

    localparam stimRowT stimTable [numRows] = '{
        '{opRead,   13'h000, 32'h0000_0000, 4'h0, 2'd0, 18'h00286},  // Version
        '{opRead,   13'h002, 32'h0000_0000, 4'h0, 2'd0, 18'h00000},
        '{opRead,   13'h040, 32'h0000_0000, 4'h0, 2'd0, 18'h00000},
        '{opRead,   13'h04c, 32'h0000_0000, 4'h0, 2'd1, 18'h00000},
        '{opWrite,  13'h044, 32'h0002_4680, 4'hf, 2'd0, 18'h00000},
        '{opRead,   13'h044, 32'h0000_0000, 4'h0, 2'd0, 18'h04680},
        '{opRead,   13'h046, 32'h0000_0000, 4'h0, 2'd0, 18'h00002},
        '{opWrite,  13'h04c, 32'hffff_1234, 4'hf, 2'd1, 18'h00000},
        '{opWrite,  13'h04c, 32'h0000_ab00, 4'h2, 2'd1, 18'h00000},  // Byte 1 only
        '{opWrite,  13'h04c, 32'h0001_0000, 4'h4, 2'd1, 18'h00000},  // Byte 2 only
        '{opRead,   13'h04c, 32'h0000_0000, 4'h0, 2'd1, 18'h0ab34},
        '{opRead,   13'h04e, 32'h0000_0000, 4'h0, 2'd1, 18'h00001},
        '{opWrite,  13'h050, 32'hffff_fff2, 4'h1, 2'd2, 18'h00000},
        '{opWrite,  13'h050, 32'h0000_0f00, 4'h2, 2'd2, 18'h00000},
        '{opRead,   13'h050, 32'h0000_0000, 4'h0, 2'd2, 18'h00002},
        '{opRead,   13'h052, 32'h0000_0000, 4'h0, 2'd2, 18'h00000},
        '{opRead,   13'h004, 32'h0000_0000, 4'h0, 2'd0, 18'h00000},  // Unmapped
        '{opRead,   13'h058, 32'h0000_0000, 4'h0, 2'd0, 18'h00000},  // No channel 3
        '{opRead,   13'h080, 32'h0000_0000, 4'h0, 2'd0, 18'h00000},
        '{opRead,   13'h1040, 32'h0000_0000, 4'h0, 2'd0, 18'h00000},
        '{opWrite,  13'h000, 32'hffff_ffff, 4'hf, 2'd0, 18'h00000},  // Version is read only
        '{opRead,   13'h000, 32'h0000_0000, 4'h0, 2'd0, 18'h00286},
        '{opWrite,  13'h040, 32'h0000_0003, 4'h1, 2'd0, 18'h00000},
        '{opWrite,  13'h048, 32'h0000_0001, 4'h1, 2'd1, 18'h00000},
        '{opStream, 13'h000, 32'h0002_4680, 4'h0, 2'd0, 18'h00003},
        '{opStream, 13'h000, 32'h0001_ab34, 4'h0, 2'd1, 18'h00001},
        '{opStream, 13'h000, 32'h0000_0000, 4'h0, 2'd2, 18'h00002},
        '{opWrite,  13'h040, 32'h0000_0002, 4'h1, 2'd0, 18'h00000},
        '{opWrite,  13'h048, 32'h0000_0000, 4'hf, 2'd1, 18'h00000},
        '{opWrite,  13'h050, 32'h0000_0009, 4'h1, 2'd2, 18'h00000},  // Unused code
        '{opWrite,  13'h054, 32'h0003_fff0, 4'hf, 2'd2, 18'h00000},
        '{opRead,   13'h054, 32'h0000_0000, 4'h0, 2'd2, 18'h0fff0},
        '{opStream, 13'h000, 32'h0002_4680, 4'h0, 2'd0, 18'h00002},
        '{opStream, 13'h000, 32'h0001_ab34, 4'h0, 2'd1, 18'h00000},
        '{opStream, 13'h000, 32'h0003_fff0, 4'h0, 2'd2, 18'h00009},
        '{opWrite,  13'h048, 32'h0000_0003, 4'h1, 2'd1, 18'h00000},
        '{opStream, 13'h000, 32'h0001_ab34, 4'h0, 2'd1, 18'h00003}
    };

    logic                              clk;
    logic                              rst;
    busReqT                            busReq;
    logic [15:0]                       readData;
    logic [adcWidth-1:0]               adc;
    sampleT [numDacs-1:0]              demodData;
    sampleT [numDacs-1:0]              stcData;
    logic [numDacs-1:0][dacWidth-1:0]  dacData;

    logic [31:0] lfsr = 32'h8b04;
    int          valueErrors = 0;
    int          timeoutErrors = 0;

    clockGen #(
        .halfPeriod  (2),
        .resetCycles (10)
    ) clkGen (
        .clk (clk),
        .rst (rst)
    );

    stcDacTop #(
        .numDacs   (numDacs),
        .verNumber (verNumber)
    ) dut (
        .clk       (clk),
        .rst       (rst),
        .busReq    (busReq),
        .readData  (readData),
        .adc       (adc),
        .demodData (demodData),
        .stcData   (stcData),
        .dacData   (dacData)
    );

    // ****************************************
    // Stimulus helpers
    // ****************************************
    // Taps 32 22 2 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    task automatic drawBits(input int width, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < width; i++) begin
            lfsr  = lfsrStep(lfsr);
            value = {value[30:0], lfsr[0]};
        end
    endtask

    // Sign bit flipped, then sample bits 16 down to 4
    function automatic logic [dacWidth-1:0] formatSample(input logic [17:0] sample);
        return {~sample[17], sample[16:4]};
    endfunction

    task automatic busWrite(input logic [addrWidth-1:0] addr, input logic [31:0] data,
                            input logic [3:0] strobes);
        @(posedge clk);
        busReq <= '{cs: 1'b1, rd: 1'b0, wr: strobes, addr: addr, wrData: data};
        @(posedge clk);
        busReq <= '0;
    endtask

    task automatic busRead(input logic [addrWidth-1:0] addr, input logic [15:0] expected);
        @(posedge clk);
        busReq <= '{cs: 1'b1, rd: 1'b1, wr: 4'h0, addr: addr, wrData: 32'h0};
        @(negedge clk);   // Read data settled
        assert (readData == expected) else begin
            valueErrors++;
            $display("ERROR readData at addr %h: got %h expected %h", addr, readData, expected);
        end
        @(posedge clk);
        busReq <= '0;
    endtask

    // Random inputs every cycle, checks once the pipeline is full
    task automatic runStream(input stimRowT row);
        logic [adcWidth-1:0] adcHist [streamLen];
        logic [17:0]         demodHist [streamLen];
        logic [17:0]         stcHist [streamLen];
        logic [31:0]         bits;
        sampleT [numDacs-1:0] demodNow;
        sampleT [numDacs-1:0] stcNow;
        logic [dacWidth-1:0] expWord;
        for (int k = 0; k < streamLen; k++) begin
            @(posedge clk);
            drawBits(adcWidth, bits);
            adcHist[k] = bits[adcWidth-1:0];
            for (int n = 0; n < numDacs; n++) begin
                drawBits(sampleWidth, bits);
                demodNow[n] = bits[sampleWidth-1:0];
                drawBits(sampleWidth, bits);
                stcNow[n] = bits[sampleWidth-1:0];
            end
            demodHist[k] = demodNow[row.chan];
            stcHist[k]   = stcNow[row.chan];
            adc       <= adcHist[k];
            demodData <= demodNow;
            stcData   <= stcNow;
            @(negedge clk);
            if (k >= 4) begin
                case (row.expected[srcWidth-1:0])
                    SRC_ADC:   expWord = adcHist[k-4];   // ADC word comes back unchanged
                    SRC_DEMOD: expWord = formatSample(demodHist[k-2]);
                    SRC_STC:   expWord = formatSample(stcHist[k-2]);
                    default:   expWord = formatSample(row.data[17:0]);
                endcase
                assert (dacData[row.chan] == expWord) else begin
                    valueErrors++;
                    $display("ERROR dacData[%0d] stream cycle %0d: got %h expected %h",
                             row.chan, k, dacData[row.chan], expWord);
                end
            end
        end
    endtask

    // ****************************************
    // Main sequence
    // ****************************************
    initial begin
        int waited;
        busReq    = '0;
        adc       = '0;
        demodData = '0;
        stcData   = '0;
        waited    = 0;

        @(negedge clk);
        while (rst && (waited < resetTimeout)) begin
            @(negedge clk);
            waited++;
        end
        assert (!rst) else begin
            timeoutErrors++;
            $display("Reset was never released");
        end

        if (timeoutErrors == 0) begin
            // Last reset edge is behind us, no data edge yet
            for (int n = 0; n < numDacs; n++) begin
                assert (dacData[n] == 14'h2000) else begin
                    valueErrors++;
                    $display("ERROR dacData[%0d] after reset: got %h expected %h",
                             n, dacData[n], 14'h2000);
                end
            end

            for (int i = 0; i < numRows; i++) begin
                case (stimTable[i].op)
                    opWrite: busWrite(stimTable[i].addr, stimTable[i].data,
                                      stimTable[i].strobes);
                    opRead:  busRead(stimTable[i].addr, stimTable[i].expected[15:0]);
                    default: runStream(stimTable[i]);
                endcase
            end
        end

        $display("Checks finished: %0d value errors, %0d timeouts",
                 valueErrors, timeoutErrors);
        if ((valueErrors == 0) && (timeoutErrors == 0)) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* files.f */
rtl/stcPkg.sv
rtl/adcCapture.sv
rtl/controlRegs.sv
rtl/dacSourceSelect.sv
rtl/dacOutput.sv
rtl/stcDacTop.sv
bench/clockGen.sv
bench/stcDacBench.sv

/* rtl/adcCapture.sv */
`timescale 1ns/1ns

module adcCapture (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [stcPkg::adcWidth-1:0] adc,
    output stcPkg::sampleT              adcSample
);

    import stcPkg::*;

    logic [adcWidth-1:0] adcReg;   // Raw offset-binary word

    // ****************************************
    // Input register
    // ****************************************
    always_ff @(posedge clk) begin
        if (rst) begin
            adcReg <= '0;
        end else begin
            adcReg <= adc;
        end
    end

    // ****************************************
    // Offset binary to signed
    // ****************************************
    // Flip the MSB and left justify into the sample width
    always_ff @(posedge clk) begin
        if (rst) begin
            adcSample <= '0;
        end else begin
            adcSample <= {~adcReg[adcWidth-1],
                          adcReg[adcWidth-2:0],
                          {(sampleWidth-adcWidth){1'b0}}};
        end
    end

endmodule

/* rtl/controlRegs.sv */
`timescale 1ns/1ns

module controlRegs #(
    parameter int          numDacs   = 3,
    parameter logic [15:0] verNumber = 16'd0
) (
    input  logic                          clk,
    input  logic                          rst,
    input  stcPkg::busReqT                busReq,
    output logic [15:0]                   readData,
    output stcPkg::dacCtrlT [numDacs-1:0] dacCtrl
);

    import stcPkg::*;

    // Each space spans 64 bytes
    localparam int spaceLsb = 6;

    logic                topSpace;
    logic                dacSpace;
    logic [spaceLsb-1:0] offset;
    logic [spaceLsb-4:0] chanSel;    // 8 bytes per channel
    logic                regSel;     // Low source, high test value
    logic                wrEn;
    regWordU             regWord;    // Addressed register contents
    regWordU             wrWord;     // Same word after the byte strobes

    // Byte-strobed merge of bus data into a register word
    function automatic regWordU mergeBytes(
        input regWordU     oldWord,
        input logic [31:0] data,
        input logic [3:0]  strobes
    );
        regWordU merged;
        merged = oldWord;
        for (int b = 0; b < 4; b++) begin
            if (strobes[b]) begin
                merged.word[8*b +: 8] = data[8*b +: 8];
            end
        end
        return merged;
    endfunction

    // ****************************************
    // Address decode
    // ****************************************
    assign topSpace = busReq.cs &&
                      (busReq.addr[addrWidth-1:spaceLsb] == TOP_SPACE[addrWidth-1:spaceLsb]);
    assign dacSpace = busReq.cs &&
                      (busReq.addr[addrWidth-1:spaceLsb] == DAC_SPACE[addrWidth-1:spaceLsb]);

    assign offset  = busReq.addr[spaceLsb-1:0];
    assign chanSel = offset[spaceLsb-1:3];
    assign regSel  = offset[2];
    assign wrEn    = busReq.cs && (|busReq.wr);

    // Current word of whatever register the bus points at
    always_comb begin
        regWord.word = '0;
        if (topSpace && (offset[spaceLsb-1:2] == '0)) begin
            regWord.word = {16'h0000, verNumber};   // Read-only version
        end
        for (int n = 0; n < numDacs; n++) begin
            if (dacSpace && (chanSel == n)) begin
                if (regSel) begin
                    regWord.word = {{(32-sampleWidth){1'b0}}, dacCtrl[n].testValue};
                end else begin
                    regWord.word = {{(32-srcWidth){1'b0}}, dacCtrl[n].source};
                end
            end
        end
    end

    assign wrWord = mergeBytes(regWord, busReq.wrData, busReq.wr);

    // ****************************************
    // DAC control registers
    // ****************************************
    always_ff @(posedge clk) begin
        if (rst) begin
            dacCtrl <= '0;   // Test value source, value 0
        end else if (wrEn && dacSpace) begin
            for (int n = 0; n < numDacs; n++) begin
                if (chanSel == n) begin
                    if (regSel) begin
                        dacCtrl[n].testValue <= wrWord.word[sampleWidth-1:0];
                    end else begin
                        dacCtrl[n].source <= wrWord.word[srcWidth-1:0];
                    end
                end
            end
        end
    end

    // ****************************************
    // Read mux
    // ****************************************
    // addr bit 1 picks the upper half
    always_comb begin
        readData = 16'h0000;
        if (busReq.rd) begin
            if (busReq.addr[1]) begin
                readData = regWord.half.hi;
            end else begin
                readData = regWord.half.lo;
            end
        end
    end

    // Bus master never mixes a read and a write in one access
    busNoRdWr: assert property (@(posedge clk) disable iff (rst)
        busReq.cs |-> !(busReq.rd && (|busReq.wr)))
        else $error("controlRegs: read and write asserted together");

endmodule

/* rtl/dacOutput.sv */
`timescale 1ns/1ns

module dacOutput #(
    parameter int numDacs = 3
) (
    input  logic                                     clk,
    input  logic                                     rst,
    input  stcPkg::sampleT [numDacs-1:0]             dacSample,
    output logic [numDacs-1:0][stcPkg::dacWidth-1:0] dacData
);

    import stcPkg::*;

    localparam logic [dacWidth-1:0] dacMid = {1'b1, {(dacWidth-1){1'b0}}};   // 14'h2000

    // ****************************************
    // Signed to offset binary
    // ****************************************
    // Top dacWidth bits of the sample with the sign flipped
    always_ff @(posedge clk) begin
        if (rst) begin
            dacData <= {numDacs{dacMid}};
        end else begin
            for (int n = 0; n < numDacs; n++) begin
                dacData[n] <= {~dacSample[n][sampleWidth-1],
                               dacSample[n][sampleWidth-2 -: dacWidth-1]};
            end
        end
    end

    // Whole path from ADC and demod inputs must settle to known levels
    dacKnown: assert property (@(posedge clk) disable iff (rst)
        !$isunknown(dacData))
        else $error("dacOutput: unknown DAC word");

endmodule

/* rtl/dacSourceSelect.sv */
`timescale 1ns/1ns

module dacSourceSelect #(
    parameter int numDacs = 3
) (
    input  logic                          clk,
    input  logic                          rst,
    input  stcPkg::sampleT                adcSample,
    input  stcPkg::sampleT  [numDacs-1:0] demodData,
    input  stcPkg::sampleT  [numDacs-1:0] stcData,
    input  stcPkg::dacCtrlT [numDacs-1:0] dacCtrl,
    output stcPkg::sampleT  [numDacs-1:0] dacSample
);

    import stcPkg::*;

    // ****************************************
    // Per channel source mux
    // ****************************************
    always_ff @(posedge clk) begin
        if (rst) begin
            dacSample <= '0;
        end else begin
            for (int n = 0; n < numDacs; n++) begin
                case (dacCtrl[n].source)
                    SRC_DEMOD: begin
                        dacSample[n] <= demodData[n];
                    end
                    SRC_STC: begin
                        dacSample[n] <= stcData[n];
                    end
                    SRC_ADC: begin
                        dacSample[n] <= adcSample;   // Shared by all channels
                    end
                    default: begin
                        dacSample[n] <= dacCtrl[n].testValue;
                    end
                endcase
            end
        end
    end

    // Register block must hand over a defined select for every channel
    srcKnown: assert property (@(posedge clk) disable iff (rst)
        !$isunknown(dacCtrl))
        else $error("dacSourceSelect: unknown DAC control word");

endmodule

/* rtl/stcDacTop.sv */
`timescale 1ns/1ns

module stcDacTop #(
    parameter int          numDacs   = 3,
    parameter logic [15:0] verNumber = 16'd646
) (
    input  logic                                     clk,
    input  logic                                     rst,

    // Register bus
    input  stcPkg::busReqT                           busReq,
    output logic [15:0]                              readData,

    // ADC and external demod outputs
    input  logic [stcPkg::adcWidth-1:0]              adc,
    input  stcPkg::sampleT [numDacs-1:0]             demodData,
    input  stcPkg::sampleT [numDacs-1:0]             stcData,

    // DAC data pins
    output logic [numDacs-1:0][stcPkg::dacWidth-1:0] dacData
);

    import stcPkg::*;

    sampleT                adcSample;
    dacCtrlT [numDacs-1:0] dacCtrl;
    sampleT  [numDacs-1:0] dacSample;

    // ****************************************
    // Registers
    // ****************************************
    controlRegs #(
        .numDacs   (numDacs),
        .verNumber (verNumber)
    ) regs (
        .clk      (clk),
        .rst      (rst),
        .busReq   (busReq),
        .readData (readData),
        .dacCtrl  (dacCtrl)
    );

    // ****************************************
    // ADC reclock
    // ****************************************
    adcCapture adcCap (
        .clk       (clk),
        .rst       (rst),
        .adc       (adc),
        .adcSample (adcSample)
    );

    // ****************************************
    // DAC source select
    // ****************************************
    dacSourceSelect #(
        .numDacs (numDacs)
    ) srcSel (
        .clk       (clk),
        .rst       (rst),
        .adcSample (adcSample),
        .demodData (demodData),
        .stcData   (stcData),
        .dacCtrl   (dacCtrl),
        .dacSample (dacSample)
    );

    // ****************************************
    // DAC output format
    // ****************************************
    dacOutput #(
        .numDacs (numDacs)
    ) dacOut (
        .clk       (clk),
        .rst       (rst),
        .dacSample (dacSample),
        .dacData   (dacData)
    );

endmodule

/* rtl/stcPkg.sv */
package stcPkg;

    // ****************************************
    // Widths
    // ****************************************
    localparam int adcWidth    = 14;
    localparam int sampleWidth = 18;
    localparam int dacWidth    = 14;
    localparam int addrWidth   = 13;
    localparam int srcWidth    = 4;

    // ****************************************
    // DAC source codes
    // ****************************************
    // Other codes pick the channel test value
    localparam logic [srcWidth-1:0] SRC_DEMOD = 4'd1;   // Downconverter output
    localparam logic [srcWidth-1:0] SRC_STC   = 4'd2;   // STC demod output
    localparam logic [srcWidth-1:0] SRC_ADC   = 4'd3;   // Captured ADC sample

    // ****************************************
    // Address map
    // ****************************************
    localparam logic [addrWidth-1:0] TOP_SPACE = 13'h000;   // Version at offset 0
    localparam logic [addrWidth-1:0] DAC_SPACE = 13'h040;   // 8 bytes per channel

    // ****************************************
    // Types
    // ****************************************
    typedef logic signed [sampleWidth-1:0] sampleT;

    typedef struct packed {
        logic                 cs;
        logic                 rd;
        logic [3:0]           wr;       // Byte write strobes
        logic [addrWidth-1:0] addr;
        logic [31:0]          wrData;
    } busReqT;

    // Read side sees the word as two 16-bit halves
    typedef struct packed {
        logic [15:0] hi;
        logic [15:0] lo;
    } regHalvesT;

    typedef union packed {
        logic [31:0] word;
        regHalvesT   half;
    } regWordU;

    // Per channel DAC control
    typedef struct packed {
        logic [srcWidth-1:0] source;
        sampleT              testValue;
    } dacCtrlT;

endpackage

/* run.sh */
#!/bin/sh
# Build and run the DAC monitor testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module stcDacBench -f files.f -Mdir obj_dir -o stcDacSim

./obj_dir/stcDacSim > sim.log 2>&1
cat sim.log

if grep -q "Regression failed" sim.log; then
    exit 1
fi
exit 0
